/* bpc_consts.svh */
`ifndef BPC_CONSTS_SVH
`define BPC_CONSTS_SVH

`define BPC_N_PROBE       8   // Probe pins sampled
`define BPC_N_ENGINE      2   // Correlation engines
`define BPC_WINDOW_EXP    6   // 64 samples per window
`define BPC_METRIC_W      8   // Metric and PWM duty width
`define BPC_PERIOD_W      8   // Sample period, stored minus one
`define BPC_PROBE_IDX_W   3   // Selects one of the probes
`define BPC_ENGINE_IDX_W  1   // Selects one of the engines

`define BPC_CFG_W         16  // Configuration word
`define BPC_RST_PERIOD_M1 15  // Period of 16 after reset

`endif

/* bpc_pkg.sv */
`default_nettype none

`include "bpc_consts.svh"

package bpc_pkg;

  // Pair write view of the config word
  typedef struct packed {
    logic [`BPC_ENGINE_IDX_W-1:0] engine; // Engine to retarget
    logic [`BPC_PROBE_IDX_W-1:0]  x;      // First probe
    logic [`BPC_PROBE_IDX_W-1:0]  y;      // Second probe
    logic [`BPC_CFG_W-`BPC_ENGINE_IDX_W-2*`BPC_PROBE_IDX_W-1:0] pad;
  } bpc_pair_view_t;

  // Period write view of the config word
  typedef struct packed {
    logic [`BPC_PERIOD_W-1:0]           period_m1; // Sample period minus one
    logic [`BPC_CFG_W-`BPC_PERIOD_W-1:0] pad;
  } bpc_period_view_t;

  // Same 16 bits, decoded per is_period
  typedef union packed {
    bpc_pair_view_t   pair;
    bpc_period_view_t period;
  } bpc_cfg_word_u;

  typedef struct packed {
    logic          is_period; // Selects the period view
    bpc_cfg_word_u word;
  } bpc_cfg_req_t;

  typedef struct packed {
    logic                    valid; // One cycle per sample period
    logic [`BPC_N_PROBE-1:0] probe; // Synchronized probe pins
  } bpc_sample_t;

  typedef struct packed {
    logic                         valid;  // One cycle per window
    logic [`BPC_ENGINE_IDX_W-1:0] engine; // Source engine
    logic [`BPC_METRIC_W-1:0]     metric; // Scaled agreement count
  } bpc_result_t;

endpackage

`default_nettype wire

/* bpc_cfg_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bpc_consts.svh"

module bpc_cfg_port (
  input  wire                    i_clk_48MHz,
  input  wire                    i_reset,
  input  wire                    i_cfg_req,   // Four-phase request
  input  wire bpc_pkg::bpc_cfg_req_t i_cfg,   // Held stable while req high
  output logic                   o_cfg_ack,
  output logic [`BPC_PERIOD_W-1:0] o_period,  // Period minus one
  output logic [`BPC_N_ENGINE-1:0][`BPC_PROBE_IDX_W-1:0] o_pair_x,
  output logic [`BPC_N_ENGINE-1:0][`BPC_PROBE_IDX_W-1:0] o_pair_y,
  output logic [`BPC_N_ENGINE-1:0] o_restart  // One pulse per applied write
);

  logic apply; // New request, not yet acknowledged

  // Ack stays high until req drops, so this fires once per transfer
  assign apply = i_cfg_req && !o_cfg_ack;

  always_ff @(posedge i_clk_48MHz) begin
    if (i_reset) begin
      o_cfg_ack <= 1'b0;
      o_period  <= `BPC_PERIOD_W'(`BPC_RST_PERIOD_M1);
      o_restart <= '0;
      for (int e = 0; e < `BPC_N_ENGINE; e++) begin
        o_pair_x[e] <= `BPC_PROBE_IDX_W'(0); // Default pair (0,1)
        o_pair_y[e] <= `BPC_PROBE_IDX_W'(1);
      end
    end else begin
      o_restart <= '0; // Pulse only
      if (apply) begin
        o_cfg_ack <= 1'b1;
        if (i_cfg.is_period) begin
          o_period  <= i_cfg.word.period.period_m1;
          o_restart <= '1; // Every engine loses its window
        end else begin
          o_pair_x[i_cfg.word.pair.engine]  <= i_cfg.word.pair.x;
          o_pair_y[i_cfg.word.pair.engine]  <= i_cfg.word.pair.y;
          o_restart[i_cfg.word.pair.engine] <= 1'b1;
        end
      end else if (!i_cfg_req) begin
        o_cfg_ack <= 1'b0; // Phase four
      end
    end
  end

  // Ack only answers a request seen on the previous edge
  a_ack_after_req: assert property (
    @(posedge i_clk_48MHz) disable iff (i_reset)
    $rose(o_cfg_ack) |-> $past(i_cfg_req)
  );

endmodule

`default_nettype wire

/* bpc_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bpc_consts.svh"

module bpc_sampler (
  input  wire                        i_clk_48MHz,
  input  wire                        i_reset,
  input  wire [`BPC_N_PROBE-1:0]     i_probe,          // Asynchronous pins
  input  wire [`BPC_PERIOD_W-1:0]    i_period,         // Period minus one
  input  wire                        i_period_restart, // Period write applied
  output bpc_pkg::bpc_sample_t       o_sample
);

  logic [`BPC_N_PROBE-1:0]  probe_meta; // First synchronizer stage
  logic [`BPC_N_PROBE-1:0]  probe_sync; // Second stage, pins two cycles back
  logic [`BPC_PERIOD_W-1:0] period_cnt;
  logic                     valid_q;

  // Payload only
  always_ff @(posedge i_clk_48MHz) begin
    probe_meta <= i_probe;
    probe_sync <= probe_meta;
  end

  always_ff @(posedge i_clk_48MHz) begin
    if (i_reset || i_period_restart) begin
      period_cnt <= '0; // Restart the period from the top
      valid_q    <= 1'b0;
    end else if (period_cnt >= i_period) begin
      period_cnt <= '0; // Wrap
      valid_q    <= 1'b1;
    end else begin
      period_cnt <= period_cnt + 1'b1;
      valid_q    <= 1'b0;
    end
  end

  assign o_sample = '{valid: valid_q, probe: probe_sync};

  // No back-to-back samples unless the period is one cycle
  a_sample_spacing: assert property (
    @(posedge i_clk_48MHz) disable iff (i_reset)
    (o_sample.valid && i_period != '0) |=> !o_sample.valid
  );

endmodule

`default_nettype wire

/* bpc_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bpc_consts.svh"

module bpc_engine #(
  parameter int ENGINE_IDX = 0 // Tag carried in the result
) (
  input  wire                           i_clk_48MHz,
  input  wire                           i_reset,
  input  wire bpc_pkg::bpc_sample_t     i_sample,
  input  wire [`BPC_PROBE_IDX_W-1:0]    i_x,       // First probe of the pair
  input  wire [`BPC_PROBE_IDX_W-1:0]    i_y,       // Second probe of the pair
  input  wire                           i_restart, // Drop the current window
  output bpc_pkg::bpc_result_t          o_result
);

  logic [`BPC_WINDOW_EXP:0]   agree_cnt;  // Matches so far in this window
  logic [`BPC_WINDOW_EXP-1:0] sample_cnt; // Samples so far in this window
  logic [`BPC_WINDOW_EXP:0]   agree_next; // Count including this sample
  logic                       match;
  logic                       window_end; // Last sample of the window
  logic                       result_valid;
  logic [`BPC_METRIC_W-1:0]   metric_q;

  assign match      = i_sample.probe[i_x] == i_sample.probe[i_y];
  assign agree_next = agree_cnt + {{`BPC_WINDOW_EXP{1'b0}}, match};
  assign window_end = i_sample.valid && (&sample_cnt);

  always_ff @(posedge i_clk_48MHz) begin
    if (i_reset || i_restart) begin
      agree_cnt  <= '0;
      sample_cnt <= '0;
    end else if (i_sample.valid) begin
      sample_cnt <= sample_cnt + 1'b1;            // Wraps to zero at window end
      agree_cnt  <= window_end ? '0 : agree_next; // Fresh window after the last sample
    end
  end

  // Restart wins over a completing window
  always_ff @(posedge i_clk_48MHz) begin
    if (i_reset || i_restart) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= window_end;
    end
  end

  // Times four, a full window saturates
  always_ff @(posedge i_clk_48MHz) begin
    if (window_end) begin
      if (agree_next[`BPC_WINDOW_EXP]) begin
        metric_q <= '1;
      end else begin
        metric_q <= {agree_next[`BPC_WINDOW_EXP-1:0],
                     {(`BPC_METRIC_W-`BPC_WINDOW_EXP){1'b0}}};
      end
    end
  end

  assign o_result = '{
    valid:  result_valid,
    engine: `BPC_ENGINE_IDX_W'(ENGINE_IDX),
    metric: metric_q
  };

endmodule

`default_nettype wire

/* bpc_pwm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bpc_consts.svh"

module bpc_pwm (
  input  wire                       i_clk_48MHz,
  input  wire                       i_reset,
  input  wire bpc_pkg::bpc_result_t i_result, // Duty source
  output logic                      o_pwm
);

  logic [`BPC_METRIC_W-1:0] pwm_cnt;      // Free-running
  logic [`BPC_METRIC_W-1:0] duty_pending; // Latest metric
  logic [`BPC_METRIC_W-1:0] duty_next;    // Pending after this cycle's load
  logic [`BPC_METRIC_W-1:0] duty_active;  // Duty of the running period

  // A metric landing on the wrap cycle still makes this wrap
  assign duty_next = i_result.valid ? i_result.metric : duty_pending;

  always_ff @(posedge i_clk_48MHz) begin
    if (i_reset) begin
      pwm_cnt      <= '0;
      duty_pending <= '0;
      duty_active  <= '0;
    end else begin
      pwm_cnt      <= pwm_cnt + 1'b1;
      duty_pending <= duty_next;
      if (&pwm_cnt) begin
        duty_active <= duty_next; // Glitch-free update at the wrap
      end
    end
  end

  // High for duty_active cycles out of 256
  assign o_pwm = pwm_cnt < duty_active;

endmodule

`default_nettype wire

/* bpc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bpc_consts.svh"

module bpc_top (
  input  wire                         i_clk_48MHz,
  input  wire                         i_reset,
  input  wire                         i_cfg_req,
  input  wire bpc_pkg::bpc_cfg_req_t  i_cfg,
  output logic                        o_cfg_ack,
  input  wire [`BPC_N_PROBE-1:0]      i_probe,
  output bpc_pkg::bpc_result_t        o_result, // Engine 0 first on a tie
  output logic [`BPC_N_ENGINE-1:0]    o_pwm
);

  logic [`BPC_PERIOD_W-1:0]                         period;
  logic [`BPC_N_ENGINE-1:0][`BPC_PROBE_IDX_W-1:0]   pair_x;
  logic [`BPC_N_ENGINE-1:0][`BPC_PROBE_IDX_W-1:0]   pair_y;
  logic [`BPC_N_ENGINE-1:0]                         restart;
  bpc_pkg::bpc_sample_t                             sample;
  bpc_pkg::bpc_result_t [`BPC_N_ENGINE-1:0]         result;
  bpc_pkg::bpc_result_t                             hold_result; // Engine 1 on a tie
  logic                                             hold_valid;

  bpc_cfg_port u_cfg_port (
    .i_clk_48MHz (i_clk_48MHz),
    .i_reset     (i_reset),
    .i_cfg_req   (i_cfg_req),
    .i_cfg       (i_cfg),
    .o_cfg_ack   (o_cfg_ack),
    .o_period    (period),
    .o_pair_x    (pair_x),
    .o_pair_y    (pair_y),
    .o_restart   (restart)
  );

  bpc_sampler u_sampler (
    .i_clk_48MHz      (i_clk_48MHz),
    .i_reset          (i_reset),
    .i_probe          (i_probe),
    .i_period         (period),
    .i_period_restart (&restart), // All engines restart only on a period write
    .o_sample         (sample)
  );

  for (genvar g = 0; g < `BPC_N_ENGINE; g++) begin : g_lane
    bpc_engine #(
      .ENGINE_IDX (g)
    ) u_engine (
      .i_clk_48MHz (i_clk_48MHz),
      .i_reset     (i_reset),
      .i_sample    (sample),
      .i_x         (pair_x[g]),
      .i_y         (pair_y[g]),
      .i_restart   (restart[g]),
      .o_result    (result[g])
    );

    bpc_pwm u_pwm (
      .i_clk_48MHz (i_clk_48MHz),
      .i_reset     (i_reset),
      .i_result    (result[g]),
      .o_pwm       (o_pwm[g])
    );
  end

  // Engine 1 waits one cycle when both finish together
  always_ff @(posedge i_clk_48MHz) begin
    if (i_reset) begin
      hold_valid <= 1'b0;
    end else begin
      hold_valid <= result[0].valid && result[1].valid;
    end
  end

  always_ff @(posedge i_clk_48MHz) begin
    hold_result <= result[1]; // Payload only
  end

  always_comb begin
    if (result[0].valid) begin
      o_result = result[0];
    end else if (hold_valid) begin
      o_result = hold_result;
    end else begin
      o_result = result[1];
    end
  end

  // Windows span many samples, so the held slot is never contested
  a_hold_free: assert property (
    @(posedge i_clk_48MHz) disable iff (i_reset)
    hold_valid |-> !result[0].valid && !result[1].valid
  );

endmodule

`default_nettype wire

/* tb_bpc_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bpc_consts.svh"

module tb_bpc_checker (
  input wire                       i_clk,
  input wire                       i_reset,
  input wire                       i_cfg_req,
  input wire                       i_cfg_ack,
  input wire bpc_pkg::bpc_result_t i_result,
  input wire [`BPC_N_ENGINE-1:0]   i_pwm
);

  bpc_pkg::bpc_result_t     exp_q [$];                    // Model results in output order
  bpc_pkg::bpc_result_t     head;
  int unsigned              n;                            // Edges since reset, PWM count mod 256
  int unsigned              high_cnt [`BPC_N_ENGINE];
  logic [`BPC_METRIC_W-1:0] last_metric [`BPC_N_ENGINE];  // Last metric seen per engine
  logic [`BPC_METRIC_W-1:0] duty_exp [`BPC_N_ENGINE];     // Duty of the running PWM period
  bit                       skip [`BPC_N_ENGINE];         // Result on the wrap edge
  bit                       req_q;
  bit                       ack_q;
  int                       errors = 0;
  int                       checks = 0;
  int                       errors_mark = 0;
  int                       checks_mark = 0;

  task automatic expect_result(input bpc_pkg::bpc_result_t r);
    exp_q.push_back(r);
  endtask

  function automatic int outstanding();
    return exp_q.size();
  endfunction

  task automatic report_error(input string msg);
    $display("checker: %s at cycle %0d", msg, n);
    errors++;
  endtask

  task automatic check_value(input string name, input int unsigned got, input int unsigned want);
    checks++;
    if (got != want) begin
      $display("[FAIL] %s: got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - checks_mark, errors - errors_mark);
    checks_mark = checks;
    errors_mark = errors;
  endtask

  task automatic report_totals();
    $display("totals: %0d checks, %0d errors", checks, errors);
  endtask

  always @(posedge i_clk) begin
    if (i_reset) begin
      n     = 0;
      req_q = 1'b0;
      ack_q = 1'b0;
      for (int e = 0; e < `BPC_N_ENGINE; e++) begin
        high_cnt[e]    = 0;
        last_metric[e] = '0; // Duty is zero out of reset
        duty_exp[e]    = '0;
        skip[e]        = 1'b0;
      end
    end else begin
      if (i_cfg_ack && !ack_q && !req_q)
        report_error("ack rose with no request pending");
      if (!i_cfg_ack && ack_q && req_q)
        report_error("ack fell while the request was still high");
      req_q = i_cfg_req;
      ack_q = i_cfg_ack;
      for (int e = 0; e < `BPC_N_ENGINE; e++) begin
        if (n % 256 == 0) begin // PWM counter at zero
          if (n != 0 && !skip[e])
            check_value($sformatf("o_pwm[%0d] high cycles", e), high_cnt[e], duty_exp[e]);
          duty_exp[e] = last_metric[e];
          high_cnt[e] = 0;
          skip[e]     = i_result.valid && i_result.engine == e; // Engine 1 may be held
        end
        high_cnt[e] += i_pwm[e];
      end
      if (i_result.valid) begin
        if (exp_q.size() == 0) begin
          report_error($sformatf("engine %0d gave a result before its window", i_result.engine));
        end else begin
          head = exp_q.pop_front();
          check_value("o_result.engine", i_result.engine, head.engine);
          check_value("o_result.metric", i_result.metric, head.metric);
        end
        last_metric[i_result.engine] = i_result.metric;
      end
      n++;
    end
  end

endmodule

`default_nettype wire

/* tb_bpc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bpc_consts.svh"

module tb_bpc;

  localparam int WINDOW      = 1 << `BPC_WINDOW_EXP;
  localparam int N_TESTS     = 4;
  localparam int MAX_WINDOWS = 2;  // Per test
  localparam int MAX_PERIOD  = 20;
  localparam int TIMEOUT_CYC = N_TESTS * MAX_WINDOWS * WINDOW * MAX_PERIOD + 2000;

  logic                        clk = 1'b0;
  logic                        reset;
  logic                        cfg_req;
  bpc_pkg::bpc_cfg_req_t       cfg;
  logic                        cfg_ack;
  logic [`BPC_N_PROBE-1:0]     probe;
  bpc_pkg::bpc_result_t        result;
  logic [`BPC_N_ENGINE-1:0]    pwm;
  logic [31:0]                 seed = 32'h653ae963;
  int                          cyc = 0;  // Rising edges seen
  int                          origin;   // Pins are sampled at origin + k * period
  int                          period;
  logic [`BPC_PROBE_IDX_W-1:0] px [`BPC_N_ENGINE]; // Model copy of each pair
  logic [`BPC_PROBE_IDX_W-1:0] py [`BPC_N_ENGINE];

  always #5 clk = ~clk;

  bpc_top uut (
    .i_clk_48MHz (clk),
    .i_reset     (reset),
    .i_cfg_req   (cfg_req),
    .i_cfg       (cfg),
    .o_cfg_ack   (cfg_ack),
    .i_probe     (probe),
    .o_result    (result),
    .o_pwm       (pwm)
  );

  tb_bpc_checker u_chk (
    .i_clk     (clk),
    .i_reset   (reset),
    .i_cfg_req (cfg_req),
    .i_cfg_ack (cfg_ack),
    .i_result  (result),
    .i_pwm     (pwm)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Four per agreement, full window pinned at the top
  function automatic logic [`BPC_METRIC_W-1:0] scale_metric(input int agree);
    return (agree >= WINDOW) ? {`BPC_METRIC_W{1'b1}} : `BPC_METRIC_W'(agree * 4);
  endfunction

  function automatic bpc_pkg::bpc_cfg_req_t pair_req(input int e, input logic [2:0] x,
                                                     input logic [2:0] y);
    bpc_pkg::bpc_cfg_req_t r;
    r                  = '0;
    r.word.pair.engine = `BPC_ENGINE_IDX_W'(e);
    r.word.pair.x      = x;
    r.word.pair.y      = y;
    return r;
  endfunction

  function automatic bpc_pkg::bpc_cfg_req_t period_req(input int p);
    bpc_pkg::bpc_cfg_req_t r;
    r                       = '0;
    r.is_period             = 1'b1;
    r.word.period.period_m1 = `BPC_PERIOD_W'(p - 1);
    return r;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
    cyc++;
    if (cyc > TIMEOUT_CYC) begin
      $display("timeout after %0d cycles with results still outstanding", cyc);
      $display("Test failed");
      $finish;
    end
  endtask

  task automatic write_cfg(input bpc_pkg::bpc_cfg_req_t w);
    cfg     = w;
    cfg_req = 1'b1;
    while (!cfg_ack) tick();
    origin  = cyc; // Applied on this edge
    cfg_req = 1'b0;
    while (cfg_ack) tick();
  endtask

  // Probes change mid-period, so each sample sees exactly one vector
  task automatic run_windows(input int n_win);
    int                      agree [`BPC_N_ENGINE];
    logic [`BPC_N_PROBE-1:0] v;
    bpc_pkg::bpc_result_t    want;
    for (int e = 0; e < `BPC_N_ENGINE; e++) agree[e] = 0;
    for (int k = 1; k <= n_win * WINDOW; k++) begin
      while (cyc < origin + k * period - period / 2) tick();
      seed  = lcg_step(seed);
      v     = seed[31:24];
      probe = v;
      for (int e = 0; e < `BPC_N_ENGINE; e++) begin
        agree[e] += (v[px[e]] == v[py[e]]);
        if (k % WINDOW == 0) begin // Engine 0 is expected first
          want     = '{valid: 1'b1, engine: `BPC_ENGINE_IDX_W'(e), metric: scale_metric(agree[e])};
          agree[e] = 0;
          u_chk.expect_result(want);
        end
      end
    end
    while (u_chk.outstanding() != 0) tick();
  endtask

  initial begin
    reset   = 1'b1;
    cfg_req = 1'b0;
    cfg     = '0;
    probe   = '0;
    period  = 16;
    for (int e = 0; e < `BPC_N_ENGINE; e++) begin
      px[e] = 3'd0; // Pair after reset
      py[e] = 3'd1;
    end
    repeat (4) tick();
    reset  = 1'b0;
    origin = cyc - 1; // Reset release acts as a restart one edge earlier
    run_windows(1);
    u_chk.finish_test("default pair");
    for (int e = 0; e < `BPC_N_ENGINE; e++) begin
      seed  = lcg_step(seed);
      px[e] = seed[26:24];
      py[e] = (e == 1) ? seed[26:24] : seed[30:28]; // Engine 1 watches one probe twice
      write_cfg(pair_req(e, px[e], py[e]));
    end
    write_cfg(period_req(period)); // Aligns both windows
    run_windows(1);
    u_chk.finish_test("pair writes");
    for (int t = 0; t < N_TESTS - 2; t++) begin
      seed   = lcg_step(seed);
      period = 8 + seed[31:24] % 13;
      write_cfg(period_req(period));
      run_windows(MAX_WINDOWS);
      u_chk.finish_test($sformatf("period %0d", period));
    end
    u_chk.report_totals();
    if (u_chk.errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
bpc_pkg.sv
bpc_cfg_port.sv
bpc_sampler.sv
bpc_engine.sv
bpc_pwm.sv
bpc_top.sv
tb_bpc_checker.sv
tb_bpc.sv
